//--- files.f
+incdir+include
verilog/cu_setup_pkg.sv
verilog/counter_ctrl_if.sv
verilog/setup_config_if.sv
verilog/request_push_if.sv
verilog/cu_setup_fsm.sv
verilog/stride_counter.sv
verilog/request_generator.sv
verilog/request_fifo.sv
verilog/cu_setup_top.sv
testbench/tb_clock.sv
testbench/cu_setup_assertions.sv
testbench/tb_cu_setup.sv

//--- include/cu_setup_defines.svh
// Widths and FIFO geometry shared by all engine blocks. The FIFO depth must be a power of two
`ifndef CU_SETUP_DEFINES_SVH
`define CU_SETUP_DEFINES_SVH

// --------------------
// Datapath widths
// --------------------
// Counter, offset and data field
`define CU_COUNT_WIDTH 32
`define CU_SHIFT_WIDTH 5
// Buffer id and burst length
`define CU_ID_WIDTH 8

// --------------------
// Request FIFO
// --------------------
`define CU_FIFO_DEPTH 16
// Engine pauses at this fill level
`define CU_FIFO_PROG_THRESH 8

// --------------------
// Cache geometry
// --------------------
`define CU_CACHE_WAYS_LOG 2
`define CU_CACHE_LINE_LOG 6

`endif

//--- testbench/cu_setup_assertions.sv
// Sampled on the rising clock. The taps assume the u_fsm, u_fifo and push_if names inside the top
`timescale 1ns/1ps

module cu_setup_assertions import cu_setup_pkg::*; (
    input logic         ap_clk,
    input logic         areset_engine,
    input logic         request_valid,
    input logic         ready_out,
    input logic         done_out,
    input setup_state_e state,
    input logic         fifo_full,
    input logic         push
);

    // Output register clears on every reset cycle
    property valid_low_in_reset;
        @(posedge ap_clk) areset_engine |=> !request_valid;
    endproperty

    // Engine reports neither ready nor done while generating
    property quiet_while_busy;
        @(posedge ap_clk) disable iff (areset_engine)
            (state == BUSY) |-> (!ready_out && !done_out);
    endproperty

    property no_push_when_full;
        @(posedge ap_clk) disable iff (areset_engine) push |-> !fifo_full;
    endproperty

    a_valid_low_in_reset: assert property (valid_low_in_reset)
        else $error("request_valid high after a reset cycle");

    a_quiet_while_busy: assert property (quiet_while_busy)
        else $error("ready_out or done_out high in BUSY");

    a_no_push_when_full: assert property (no_push_when_full)
        else $error("push into a full request FIFO");

endmodule : cu_setup_assertions

bind cu_setup_top cu_setup_assertions u_assertions (
    .ap_clk        (ap_clk),
    .areset_engine (areset_engine),
    .request_valid (request_valid),
    .ready_out     (ready_out),
    .done_out      (done_out),
    .state         (u_fsm.state),
    .fifo_full     (u_fifo.full),
    .push          (push_if.push)
);

//--- testbench/tb_clock.sv
// Free running clock from time zero. The period should be an even number of ns
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS = 8
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    // Half period toggle
    always begin
        #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule : tb_clock

//--- testbench/tb_cu_setup.sv
// Fixed seed random runs. Counts stay below 2^17 so the model never sees a wrapping counter
`timescale 1ns/1ps
`include "cu_setup_defines.svh"

module tb_cu_setup;

    localparam int NUM_RUNS    = 12;
    localparam int HOLD_CYCLES = 60;

    typedef struct packed {
        logic [`CU_COUNT_WIDTH-1:0] offset;
        logic [`CU_COUNT_WIDTH-1:0] field;
        logic [`CU_ID_WIDTH-1:0]    id_buffer;
        logic [`CU_ID_WIDTH-1:0]    burst_length;
    } expected_req_t;

    logic                       ap_clk;
    logic                       areset_engine;
    logic                       config_valid;
    logic [`CU_COUNT_WIDTH-1:0] start_read;
    logic [`CU_COUNT_WIDTH-1:0] end_read;
    logic [`CU_COUNT_WIDTH-1:0] stride;
    logic [`CU_SHIFT_WIDTH-1:0] shift_amount;
    logic                       shift_left;
    logic                       flush_mode;
    logic [`CU_ID_WIDTH-1:0]    id_buffer;
    logic [`CU_ID_WIDTH-1:0]    burst_length;
    logic                       start_in;
    logic                       rd_en;
    logic                       request_valid;
    logic [`CU_COUNT_WIDTH-1:0] request_offset;
    logic [`CU_COUNT_WIDTH-1:0] request_field;
    logic [`CU_ID_WIDTH-1:0]    request_id_buffer;
    logic [`CU_ID_WIDTH-1:0]    request_burst_length;
    logic                       ready_out;
    logic                       done_out;

    logic [31:0]   rng_state;
    logic          plan_ready = 1'b0;
    int            mismatch_count;
    int            failure_count;
    int            watchdog_cycles;
    int            popped;
    expected_req_t expected_q[$];

    // Per run stimulus, mode 0 shifts left, 1 shifts right, 2 is flush
    logic [31:0] run_start  [NUM_RUNS];
    logic [31:0] run_end    [NUM_RUNS];
    logic [31:0] run_stride [NUM_RUNS];
    logic [31:0] run_shift  [NUM_RUNS];
    logic [31:0] run_id     [NUM_RUNS];
    logic [31:0] run_burst  [NUM_RUNS];
    logic        run_left   [NUM_RUNS];
    int          run_mode   [NUM_RUNS];
    int          run_duty   [NUM_RUNS];

    tb_clock #(.PERIOD_NS(8)) u_clock (.clk(ap_clk));

    cu_setup_top u_dut (
        .ap_clk               (ap_clk),
        .areset_engine        (areset_engine),
        .config_valid         (config_valid),
        .start_read           (start_read),
        .end_read             (end_read),
        .stride               (stride),
        .shift_amount         (shift_amount),
        .shift_left           (shift_left),
        .flush_mode           (flush_mode),
        .id_buffer            (id_buffer),
        .burst_length         (burst_length),
        .start_in             (start_in),
        .rd_en                (rd_en),
        .request_valid        (request_valid),
        .request_offset       (request_offset),
        .request_field        (request_field),
        .request_id_buffer    (request_id_buffer),
        .request_burst_length (request_burst_length),
        .ready_out            (ready_out),
        .done_out             (done_out)
    );

    // --------------------
    // Model helpers
    // --------------------
    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic logic [31:0] predict_offset(input logic [31:0] count,
                                                   input logic [4:0] shift,
                                                   input int mode);
        logic [31:0] way;
        logic [31:0] upper;
        way   = count & ((32'd1 << `CU_CACHE_WAYS_LOG) - 32'd1);
        upper = count >> `CU_CACHE_WAYS_LOG;
        if (mode == 2) begin
            return (upper << (`CU_CACHE_LINE_LOG + `CU_CACHE_WAYS_LOG))
                 | (way << `CU_CACHE_LINE_LOG);
        end else if (mode == 0) begin
            return count << shift;
        end
        return count >> shift;
    endfunction

    task automatic plan_runs();
        int len;
        int total;
        total = 0;
        for (int i = 0; i < NUM_RUNS; i++) begin
            len           = 5 + int'(next_random() % 36);
            run_mode[i]   = i % 3;
            run_start[i]  = next_random() & 32'hffff;
            run_stride[i] = (next_random() % 64) + 1;
            // End lands anywhere after the last count and before the next one
            run_end[i]    = run_start[i] + (len - 1) * run_stride[i] + 1
                          + (next_random() % run_stride[i]);
            run_shift[i]  = next_random() % 32;
            run_id[i]     = next_random() & 32'hff;
            run_burst[i]  = next_random() & 32'hff;
            run_left[i]   = next_random() & 32'h1;
            run_duty[i]   = 1 + int'(next_random() % 8);
            total         = total + len;
        end
        watchdog_cycles = total * 200 + 2000;
    endtask

    task automatic compare_value(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
        assert (got === exp) else begin
            mismatch_count++;
            $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // One clock, then checks any request that left the FIFO
    task automatic tick();
        expected_req_t exp_req;
        @(negedge ap_clk);
        if (request_valid === 1'b1) begin
            popped++;
            assert (expected_q.size() != 0) else begin
                failure_count++;
                $display("ERROR at %0t: a request came out when none was expected", $time);
            end
            if (expected_q.size() != 0) begin
                exp_req = expected_q.pop_front();
                compare_value("request_field", request_field, exp_req.field);
                compare_value("request_offset", request_offset, exp_req.offset);
                compare_value("request_id_buffer", 32'(request_id_buffer), 32'(exp_req.id_buffer));
                compare_value("request_burst_length", 32'(request_burst_length),
                              32'(exp_req.burst_length));
            end
        end
    endtask

    // --------------------
    // One engine run
    // --------------------
    task automatic do_run(input int idx, input bit hold);
        expected_req_t exp_req;
        logic [31:0]   c;
        int            predicted;
        int            cycles;
        predicted = 0;
        popped    = 0;
        c = run_start[idx];
        while (c < run_end[idx]) begin
            exp_req.field        = c;
            exp_req.offset       = predict_offset(c, run_shift[idx][4:0], run_mode[idx]);
            exp_req.id_buffer    = run_id[idx][7:0];
            exp_req.burst_length = run_burst[idx][7:0];
            expected_q.push_back(exp_req);
            predicted++;
            c = c + run_stride[idx];
        end

        config_valid = 1'b1;
        start_in     = 1'b1;
        start_read   = run_start[idx];
        end_read     = run_end[idx];
        stride       = run_stride[idx];
        shift_amount = run_shift[idx][4:0];
        shift_left   = (run_mode[idx] == 0) ? 1'b1 : (run_mode[idx] == 1) ? 1'b0 : run_left[idx];
        flush_mode   = (run_mode[idx] == 2);
        id_buffer    = run_id[idx][7:0];
        burst_length = run_burst[idx][7:0];
        tick();
        config_valid = 1'b0;
        start_in     = 1'b0;

        cycles = 0;
        while (ready_out === 1'b1 && cycles < 3) begin
            tick();
            cycles++;
        end
        assert (ready_out === 1'b0) else begin
            failure_count++;
            $display("ERROR at %0t: ready_out still high 3 cycles after start", $time);
        end

        cycles = 0;
        while (done_out !== 1'b1) begin
            if (hold && cycles < HOLD_CYCLES) begin
                rd_en = 1'b0;
            end else begin
                rd_en = (next_random() % 8) < run_duty[idx];
            end
            tick();
            cycles++;
            if (hold && cycles <= HOLD_CYCLES) begin
                assert (done_out !== 1'b1) else begin
                    failure_count++;
                    $display("ERROR at %0t: done_out rose while the FIFO was held full", $time);
                end
            end
        end

        assert (expected_q.size() == 0 && popped == predicted) else begin
            failure_count++;
            $display("ERROR at %0t: done_out rose after %0d of %0d requests", $time,
                     popped, predicted);
        end
        // Nothing more may come out once done, even with the consumer still reading
        rd_en = 1'b1;
        repeat (3) tick();
        rd_en = 1'b0;
        assert (ready_out === 1'b1) else begin
            failure_count++;
            $display("ERROR at %0t: engine not back in idle after run %0d", $time, idx);
        end
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        int cycles;
        areset_engine  = 1'b1;
        config_valid   = 1'b0;
        start_read     = '0;
        end_read       = '0;
        stride         = '0;
        shift_amount   = '0;
        shift_left     = 1'b0;
        flush_mode     = 1'b0;
        id_buffer      = '0;
        burst_length   = '0;
        start_in       = 1'b0;
        rd_en          = 1'b0;
        mismatch_count = 0;
        failure_count  = 0;
        popped         = 0;
        rng_state      = 32'h7bff;
        plan_runs();
        plan_ready = 1'b1;

        repeat (10) @(posedge ap_clk);
        @(negedge ap_clk);
        compare_value("request_valid in reset", 32'(request_valid), 32'd0);
        areset_engine = 1'b0;

        cycles = 0;
        while (!(ready_out === 1'b1 && done_out === 1'b1) && cycles < 5) begin
            tick();
            cycles++;
        end
        assert (ready_out === 1'b1 && done_out === 1'b1) else begin
            failure_count++;
            $display("ERROR at %0t: engine did not reach idle after reset", $time);
        end
        compare_value("request_valid after reset", 32'(request_valid), 32'd0);

        for (int i = 0; i < NUM_RUNS; i++) begin
            do_run(i, (i % 4) == 3);
        end

        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // Limit scales with the planned request count
    initial begin
        wait (plan_ready === 1'b1);
        repeat (watchdog_cycles) @(posedge ap_clk);
        failure_count++;
        $display("ERROR at %0t: run did not finish within %0d cycles", $time, watchdog_cycles);
        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        $display("** FAIL **");
        $finish;
    end

endmodule : tb_cu_setup

//--- verilog/counter_ctrl_if.sv
// Load has priority over enable at the counter. The count is unsigned and wraps
`timescale 1ns/1ps
`include "cu_setup_defines.svh"

interface counter_ctrl_if;

    logic                       enable;
    logic                       load;
    logic [`CU_COUNT_WIDTH-1:0] load_value;
    logic [`CU_COUNT_WIDTH-1:0] stride_value;
    logic [`CU_COUNT_WIDTH-1:0] count;

    // Controller side, also watches the count for the end test
    modport ctrl (
        output enable,
        output load,
        output load_value,
        output stride_value,
        input  count
    );

    // Counter register side
    modport cnt (
        input  enable,
        input  load,
        input  load_value,
        input  stride_value,
        output count
    );

    modport view (input count);

endinterface : counter_ctrl_if

//--- verilog/cu_setup_fsm.sv
// Config is sampled while config_valid is high. A start is taken in IDLE or DONE only
`timescale 1ns/1ps
`include "cu_setup_defines.svh"

module cu_setup_fsm import cu_setup_pkg::*; (
    input  logic                       ap_clk,
    input  logic                       areset_engine,
    input  logic                       config_valid,
    input  logic                       start_in,
    input  logic [`CU_COUNT_WIDTH-1:0] start_read,
    input  logic [`CU_COUNT_WIDTH-1:0] end_read,
    input  logic [`CU_COUNT_WIDTH-1:0] stride,
    input  logic [`CU_SHIFT_WIDTH-1:0] shift_amount,
    input  logic                       shift_left,
    input  logic                       flush_mode,
    input  logic [`CU_ID_WIDTH-1:0]    id_buffer,
    input  logic [`CU_ID_WIDTH-1:0]    burst_length,
    counter_ctrl_if.ctrl               cnt_ctrl,
    setup_config_if.src                cfg,
    request_push_if.status             fifo_stat,
    output logic                       ready_out,
    output logic                       done_out,
    output logic                       gen_enable
);

    setup_state_e state;
    setup_state_e next_state;

    logic start_reg;
    logic config_valid_reg;
    logic run_done;

    // Input stage copy of the configuration
    logic [`CU_COUNT_WIDTH-1:0] in_start_read;
    logic [`CU_COUNT_WIDTH-1:0] in_end_read;
    logic [`CU_COUNT_WIDTH-1:0] in_stride;
    logic [`CU_SHIFT_WIDTH-1:0] in_shift_amount;
    logic                       in_shift_left;
    logic                       in_flush_mode;
    logic [`CU_ID_WIDTH-1:0]    in_id_buffer;
    logic [`CU_ID_WIDTH-1:0]    in_burst_length;

    // Values held for the running pass
    logic [`CU_COUNT_WIDTH-1:0] run_end_read;
    logic [`CU_COUNT_WIDTH-1:0] run_stride;

    // --------------------
    // Input registers
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            start_reg        <= 1'b0;
            config_valid_reg <= 1'b0;
        end else begin
            start_reg        <= start_in;
            config_valid_reg <= config_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (config_valid) begin
            in_start_read   <= start_read;
            in_end_read     <= end_read;
            in_stride       <= stride;
            in_shift_amount <= shift_amount;
            in_shift_left   <= shift_left;
            in_flush_mode   <= flush_mode;
            in_id_buffer    <= id_buffer;
            in_burst_length <= burst_length;
        end
    end

    // Run configuration is frozen on the way through SETUP
    always_ff @(posedge ap_clk) begin
        if (state == SETUP) begin
            run_end_read     <= in_end_read;
            run_stride       <= in_stride;
            cfg.shift_amount <= in_shift_amount;
            cfg.shift_left   <= in_shift_left;
            cfg.flush_mode   <= in_flush_mode;
            cfg.id_buffer    <= in_id_buffer;
            cfg.burst_length <= in_burst_length;
        end
    end

    // --------------------
    // State machine
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            state <= RESET;
        end else begin
            state <= next_state;
        end
    end

    // Count has reached or passed the end
    assign run_done = (cnt_ctrl.count >= run_end_read);

    always_comb begin
        next_state = state;
        case (state)
            RESET:       next_state = IDLE;
            IDLE, DONE: begin
                if (start_reg && config_valid_reg) begin
                    next_state = SETUP;
                end else begin
                    next_state = IDLE;
                end
            end
            SETUP:       next_state = START;
            START:       next_state = BUSY;
            BUSY: begin
                if (run_done) begin
                    next_state = DONE;
                end else if (fifo_stat.prog_full) begin
                    next_state = PAUSE_TRANS;
                end
            end
            PAUSE_TRANS: next_state = run_done ? DONE : PAUSE;
            PAUSE: begin
                if (run_done) begin
                    next_state = DONE;
                end else if (!fifo_stat.prog_full) begin
                    next_state = BUSY_TRANS;
                end
            end
            BUSY_TRANS:  next_state = BUSY;
            default:     next_state = RESET;
        endcase
    end

    // --------------------
    // Outputs
    // --------------------
    assign gen_enable = ((state == BUSY) || (state == PAUSE_TRANS)) && !run_done;

    // Counter loads in SETUP and steps with every generated request
    assign cnt_ctrl.load         = (state == SETUP);
    assign cnt_ctrl.load_value   = in_start_read;
    assign cnt_ctrl.enable       = gen_enable;
    assign cnt_ctrl.stride_value = run_stride;

    assign ready_out = (state == IDLE);
    // Done waits for the last queued request to leave
    assign done_out  = ((state == IDLE) || (state == DONE)) && fifo_stat.empty;

endmodule : cu_setup_fsm

//--- verilog/cu_setup_pkg.sv
// Engine state encoding only. The FSM falls back to RESET from any unused code
package cu_setup_pkg;

    // Serial read engine states
    typedef enum logic [3:0] {
        RESET       = 4'd0,
        IDLE        = 4'd1,
        SETUP       = 4'd2,
        START       = 4'd3,
        BUSY        = 4'd4,
        // One more request goes out on the way into PAUSE
        PAUSE_TRANS = 4'd5,
        PAUSE       = 4'd6,
        // Idle cycle before generation restarts
        BUSY_TRANS  = 4'd7,
        DONE        = 4'd8
    } setup_state_e;

endpackage : cu_setup_pkg

//--- verilog/cu_setup_top.sv
// Hold config_valid with start_in for one cycle at least. Request fields hold between pops
`timescale 1ns/1ps
`include "cu_setup_defines.svh"

module cu_setup_top (
    input  logic                       ap_clk,
    input  logic                       areset_engine,
    input  logic                       config_valid,
    input  logic [`CU_COUNT_WIDTH-1:0] start_read,
    input  logic [`CU_COUNT_WIDTH-1:0] end_read,
    input  logic [`CU_COUNT_WIDTH-1:0] stride,
    input  logic [`CU_SHIFT_WIDTH-1:0] shift_amount,
    input  logic                       shift_left,
    input  logic                       flush_mode,
    input  logic [`CU_ID_WIDTH-1:0]    id_buffer,
    input  logic [`CU_ID_WIDTH-1:0]    burst_length,
    input  logic                       start_in,
    input  logic                       rd_en,
    output logic                       request_valid,
    output logic [`CU_COUNT_WIDTH-1:0] request_offset,
    output logic [`CU_COUNT_WIDTH-1:0] request_field,
    output logic [`CU_ID_WIDTH-1:0]    request_id_buffer,
    output logic [`CU_ID_WIDTH-1:0]    request_burst_length,
    output logic                       ready_out,
    output logic                       done_out
);

    logic gen_enable;

    counter_ctrl_if cnt_if ();
    setup_config_if cfg_if ();
    request_push_if push_if ();

    // --------------------
    // Control
    // --------------------
    cu_setup_fsm u_fsm (
        .ap_clk        (ap_clk),
        .areset_engine (areset_engine),
        .config_valid  (config_valid),
        .start_in      (start_in),
        .start_read    (start_read),
        .end_read      (end_read),
        .stride        (stride),
        .shift_amount  (shift_amount),
        .shift_left    (shift_left),
        .flush_mode    (flush_mode),
        .id_buffer     (id_buffer),
        .burst_length  (burst_length),
        .cnt_ctrl      (cnt_if.ctrl),
        .cfg           (cfg_if.src),
        .fifo_stat     (push_if.status),
        .ready_out     (ready_out),
        .done_out      (done_out),
        .gen_enable    (gen_enable)
    );

    stride_counter u_counter (
        .ap_clk        (ap_clk),
        .areset_engine (areset_engine),
        .ctrl          (cnt_if.cnt)
    );

    // --------------------
    // Datapath
    // --------------------
    request_generator u_gen (
        .ap_clk        (ap_clk),
        .areset_engine (areset_engine),
        .gen_enable    (gen_enable),
        .cnt           (cnt_if.view),
        .cfg           (cfg_if.dst),
        .req           (push_if.gen)
    );

    request_fifo u_fifo (
        .ap_clk               (ap_clk),
        .areset_engine        (areset_engine),
        .req                  (push_if.fifo),
        .rd_en                (rd_en),
        .request_valid        (request_valid),
        .request_offset       (request_offset),
        .request_field        (request_field),
        .request_id_buffer    (request_id_buffer),
        .request_burst_length (request_burst_length)
    );

endmodule : cu_setup_top

//--- verilog/request_fifo.sv
// Depth must be a power of two. A push while full is dropped
`timescale 1ns/1ps
`include "cu_setup_defines.svh"

module request_fifo (
    input  logic                       ap_clk,
    input  logic                       areset_engine,
    request_push_if.fifo               req,
    input  logic                       rd_en,
    output logic                       request_valid,
    output logic [`CU_COUNT_WIDTH-1:0] request_offset,
    output logic [`CU_COUNT_WIDTH-1:0] request_field,
    output logic [`CU_ID_WIDTH-1:0]    request_id_buffer,
    output logic [`CU_ID_WIDTH-1:0]    request_burst_length
);

    localparam int DEPTH   = `CU_FIFO_DEPTH;
    localparam int PTR_W   = $clog2(DEPTH);
    localparam int ENTRY_W = 2 * `CU_COUNT_WIDTH + 2 * `CU_ID_WIDTH;

    logic [ENTRY_W-1:0] mem [DEPTH];
    logic [ENTRY_W-1:0] wr_data;
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W:0]     occupancy;
    logic               full;
    logic               wr;
    logic               rd;

    assign full          = (occupancy == (PTR_W+1)'(DEPTH));
    assign req.empty     = (occupancy == '0);
    assign req.prog_full = (occupancy >= (PTR_W+1)'(`CU_FIFO_PROG_THRESH));

    assign wr = req.push && !full;
    assign rd = rd_en && !req.empty;

    assign wr_data = {req.offset, req.field, req.id_buffer, req.burst_length};

    // --------------------
    // Pointers and fill
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            occupancy <= '0;
        end else begin
            if (wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves the fill unchanged
            case ({wr, rd})
                2'b10:   occupancy <= occupancy + 1'b1;
                2'b01:   occupancy <= occupancy - 1'b1;
                default: occupancy <= occupancy;
            endcase
        end
    end

    always_ff @(posedge ap_clk) begin
        if (wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // --------------------
    // Output register
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            request_valid <= 1'b0;
        end else begin
            request_valid <= rd;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (rd) begin
            {request_offset, request_field, request_id_buffer, request_burst_length}
                <= mem[rd_ptr];
        end
    end

endmodule : request_fifo

//--- verilog/request_generator.sv
// Shifts drop bits beyond 32. Flush mode ignores the shift settings entirely
`timescale 1ns/1ps
`include "cu_setup_defines.svh"

module request_generator (
    input  logic         ap_clk,
    input  logic         areset_engine,
    input  logic         gen_enable,
    counter_ctrl_if.view cnt,
    setup_config_if.dst  cfg,
    request_push_if.gen  req
);

    localparam int WAYS_LOG = `CU_CACHE_WAYS_LOG;
    localparam int LINE_LOG = `CU_CACHE_LINE_LOG;

    logic [`CU_COUNT_WIDTH-1:0] offset_comb;
    logic [`CU_COUNT_WIDTH-1:0] flush_offset;
    logic [`CU_COUNT_WIDTH-1:0] way_bits;

    // --------------------
    // Offset calculation
    // --------------------
    // Low count bits select the way
    assign way_bits = {{(`CU_COUNT_WIDTH-WAYS_LOG){1'b0}}, cnt.count[WAYS_LOG-1:0]};

    // Remaining bits step over whole sets of lines
    assign flush_offset = ((cnt.count >> WAYS_LOG) << (LINE_LOG + WAYS_LOG))
                        | (way_bits << LINE_LOG);

    always_comb begin
        if (cfg.flush_mode) begin
            offset_comb = flush_offset;
        end else if (cfg.shift_left) begin
            offset_comb = cnt.count << cfg.shift_amount;
        end else begin
            offset_comb = cnt.count >> cfg.shift_amount;
        end
    end

    // --------------------
    // Push register
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            req.push <= 1'b0;
        end else begin
            req.push <= gen_enable;
        end
    end

    // Payload follows the count of the generating cycle
    always_ff @(posedge ap_clk) begin
        req.offset       <= offset_comb;
        req.field        <= cnt.count;
        req.id_buffer    <= cfg.id_buffer;
        req.burst_length <= cfg.burst_length;
    end

endmodule : request_generator

//--- verilog/request_push_if.sv
// One entry is written per cycle with push high. Status is registered inside the FIFO
`timescale 1ns/1ps
`include "cu_setup_defines.svh"

interface request_push_if;

    logic                       push;
    logic [`CU_COUNT_WIDTH-1:0] offset;
    logic [`CU_COUNT_WIDTH-1:0] field;
    logic [`CU_ID_WIDTH-1:0]    id_buffer;
    logic [`CU_ID_WIDTH-1:0]    burst_length;
    logic                       prog_full;
    logic                       empty;

    // Request producer
    modport gen (
        output push,
        output offset,
        output field,
        output id_buffer,
        output burst_length
    );

    // Storage side
    modport fifo (
        input  push,
        input  offset,
        input  field,
        input  id_buffer,
        input  burst_length,
        output prog_full,
        output empty
    );

    // Fill level seen by the FSM
    modport status (input prog_full, input empty);

endinterface : request_push_if

//--- verilog/setup_config_if.sv
// Fields are stable for a whole run. They change only when the FSM passes through SETUP
`timescale 1ns/1ps
`include "cu_setup_defines.svh"

interface setup_config_if;

    logic [`CU_SHIFT_WIDTH-1:0] shift_amount;
    // High selects a left shift of the count
    logic                       shift_left;
    // Cache way and line spreading, overrides the shift
    logic                       flush_mode;
    logic [`CU_ID_WIDTH-1:0]    id_buffer;
    logic [`CU_ID_WIDTH-1:0]    burst_length;

    modport src (
        output shift_amount,
        output shift_left,
        output flush_mode,
        output id_buffer,
        output burst_length
    );

    modport dst (
        input shift_amount,
        input shift_left,
        input flush_mode,
        input id_buffer,
        input burst_length
    );

endinterface : setup_config_if

//--- verilog/stride_counter.sv
// Count steps up only. Overflow past the top of the range wraps silently
`timescale 1ns/1ps

module stride_counter (
    input  logic        ap_clk,
    input  logic        areset_engine,
    counter_ctrl_if.cnt ctrl
);

    // Load wins over a stride step in the same cycle
    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            ctrl.count <= '0;
        end else if (ctrl.load) begin
            ctrl.count <= ctrl.load_value;
        end else if (ctrl.enable) begin
            ctrl.count <= ctrl.count + ctrl.stride_value;
        end
    end

endmodule : stride_counter
